//--- rtl/rv_isa_pkg.sv
// RV32 instruction-level types for the execute logic
// modules refer to these by scoped name, nothing is imported
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0]   word_t;
	typedef logic [2*xlen-1:0] dword_t;  // full multiply product
	typedef logic [31:0]       inst_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_func_t;

	typedef enum logic [1:0] {
		mult_mul, mult_mulh, mult_mulhsu, mult_mulhu
	} mult_func_t;

	// funct3 encodings of the conditional branches
	typedef enum logic [2:0] {
		br_eq  = 3'b000,
		br_ne  = 3'b001,
		br_lt  = 3'b100,
		br_ge  = 3'b101,
		br_ltu = 3'b110,
		br_geu = 3'b111
	} br_funct_t;

	typedef enum logic [1:0] {opa_rs1, opa_npc, opa_pc, opa_zero} opa_sel_t;

	typedef enum logic [1:0] {opb_rs2, opb_i_imm, opb_b_imm} opb_sel_t;

endpackage

//--- rtl/ex_cfg_pkg.sv
// sizing and unit selection for the single-slot execute stage
// mult_step_bits follows from the product width and stage count
package ex_cfg_pkg;

	localparam int tag_bits = 6;

	// tag 0 is the zero register, completes but never writes
	typedef logic [tag_bits-1:0] tag_t;

	localparam int mult_stages    = 4;
	localparam int mult_step_bits = 2 * rv_isa_pkg::xlen / mult_stages;  // 16

	localparam int cq_depth = 8;

	typedef logic [$clog2(cq_depth)-1:0] cq_ptr_t;

	typedef enum logic [1:0] {
		unit_alu,
		unit_mult,
		unit_branch
	} exec_unit_t;

endpackage

//--- rtl/int_exec.sv
// integer path: operand muxes, ALU and branch condition, all combinational
// result and branch outcome are valid in the issue cycle
`timescale 1ns/10ps

module int_exec (
	input  ex_cfg_pkg::exec_unit_t exec_unit,
	input  logic                   start,
	input  rv_isa_pkg::alu_func_t  alu_func,
	input  rv_isa_pkg::opa_sel_t   opa_sel,
	input  rv_isa_pkg::opb_sel_t   opb_sel,
	input  rv_isa_pkg::inst_t      inst,
	input  rv_isa_pkg::word_t      pc,
	input  rv_isa_pkg::word_t      npc,
	input  rv_isa_pkg::word_t      rs1_value,
	input  rv_isa_pkg::word_t      rs2_value,
	input  ex_cfg_pkg::tag_t       dest_tag,
	input  logic                   cond_branch,
	input  logic                   uncond_branch,
	output logic                   done,
	output ex_cfg_pkg::tag_t       tag,
	output rv_isa_pkg::word_t      result,
	output logic                   take,
	output rv_isa_pkg::word_t      target
);

	rv_isa_pkg::word_t opa, opb;
	rv_isa_pkg::word_t i_imm, b_imm;
	rv_isa_pkg::word_t alu_result;
	logic              br_cond;

	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	//////////////////////////////////////////////////
	// operand select

	always_comb begin
		case (opa_sel)
			rv_isa_pkg::opa_rs1: opa = rs1_value;
			rv_isa_pkg::opa_npc: opa = npc;
			rv_isa_pkg::opa_pc:  opa = pc;
			default:             opa = '0;  // opa_zero
		endcase
	end

	always_comb begin
		case (opb_sel)
			rv_isa_pkg::opb_rs2:   opb = rs2_value;
			rv_isa_pkg::opb_i_imm: opb = i_imm;
			rv_isa_pkg::opb_b_imm: opb = b_imm;
			default:               opb = '0;  // unused encoding
		endcase
	end

	//////////////////////////////////////////////////
	// ALU

	always_comb begin
		case (alu_func)
			rv_isa_pkg::alu_add:  alu_result = opa + opb;
			rv_isa_pkg::alu_sub:  alu_result = opa - opb;
			rv_isa_pkg::alu_and:  alu_result = opa & opb;
			rv_isa_pkg::alu_or:   alu_result = opa | opb;
			rv_isa_pkg::alu_xor:  alu_result = opa ^ opb;
			rv_isa_pkg::alu_slt:  alu_result = rv_isa_pkg::word_t'($signed(opa) < $signed(opb));
			rv_isa_pkg::alu_sltu: alu_result = rv_isa_pkg::word_t'(opa < opb);
			rv_isa_pkg::alu_sll:  alu_result = opa << opb[4:0];
			rv_isa_pkg::alu_srl:  alu_result = opa >> opb[4:0];
			rv_isa_pkg::alu_sra:  alu_result = $signed(opa) >>> opb[4:0];
			default:              alu_result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// branch condition, always on the register values

	always_comb begin
		case (rv_isa_pkg::br_funct_t'(inst[14:12]))
			rv_isa_pkg::br_eq:  br_cond = (rs1_value == rs2_value);
			rv_isa_pkg::br_ne:  br_cond = (rs1_value != rs2_value);
			rv_isa_pkg::br_lt:  br_cond = ($signed(rs1_value) < $signed(rs2_value));
			rv_isa_pkg::br_ge:  br_cond = ($signed(rs1_value) >= $signed(rs2_value));
			rv_isa_pkg::br_ltu: br_cond = (rs1_value < rs2_value);
			rv_isa_pkg::br_geu: br_cond = (rs1_value >= rs2_value);
			default:            br_cond = 1'b0;
		endcase
	end

	assign done   = start;
	assign tag    = dest_tag;
	assign target = opa + opb;
	assign take   = uncond_branch | (cond_branch & br_cond);  // queue samples only on done

	// link value for branches and jumps
	assign result = ((exec_unit == ex_cfg_pkg::unit_branch) || uncond_branch) ? npc : alu_result;

endmodule

//--- rtl/mult_pipe.sv
// pipelined multiplier, one 16-bit slice of the multiplier per stage
// done, tag and product leave mult_stages cycles after issue
`timescale 1ns/10ps

module mult_pipe (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  rv_isa_pkg::mult_func_t func,
	input  rv_isa_pkg::word_t      mcand,
	input  rv_isa_pkg::word_t      mplier,
	input  ex_cfg_pkg::tag_t       dest_tag,
	input  logic                   flush,
	output logic                   done,
	output ex_cfg_pkg::tag_t       tag,
	output rv_isa_pkg::word_t      product
);

	logic                   stage_valid  [0:ex_cfg_pkg::mult_stages];
	ex_cfg_pkg::tag_t       stage_tag    [0:ex_cfg_pkg::mult_stages];
	rv_isa_pkg::mult_func_t stage_func   [0:ex_cfg_pkg::mult_stages];
	rv_isa_pkg::dword_t     stage_prod   [0:ex_cfg_pkg::mult_stages];
	rv_isa_pkg::dword_t     stage_mcand  [0:ex_cfg_pkg::mult_stages-1];
	rv_isa_pkg::dword_t     stage_mplier [0:ex_cfg_pkg::mult_stages-1];
	logic                   mcand_signed, mplier_signed;

	// rs1 is signed except for mulhu, rs2 only for mul and mulh
	assign mcand_signed  = (func != rv_isa_pkg::mult_mulhu);
	assign mplier_signed = (func == rv_isa_pkg::mult_mul) || (func == rv_isa_pkg::mult_mulh);

	assign stage_valid[0]  = start;
	assign stage_tag[0]    = dest_tag;
	assign stage_func[0]   = func;
	assign stage_prod[0]   = '0;
	assign stage_mcand[0]  = {{rv_isa_pkg::xlen{mcand_signed & mcand[rv_isa_pkg::xlen-1]}},
		mcand};
	assign stage_mplier[0] = {{rv_isa_pkg::xlen{mplier_signed & mplier[rv_isa_pkg::xlen-1]}},
		mplier};

	for (genvar i = 0; i < ex_cfg_pkg::mult_stages; i++) begin : g_stage
		rv_isa_pkg::dword_t partial;

		assign partial = stage_mcand[i] *
			rv_isa_pkg::dword_t'(stage_mplier[i][ex_cfg_pkg::mult_step_bits-1:0]);

		always_ff @(posedge clock) begin
			if (reset || flush) begin
				stage_valid[i+1] <= 1'b0;  // squash everything in flight
			end else begin
				stage_valid[i+1] <= stage_valid[i];
			end
		end

		always_ff @(posedge clock) begin
			stage_tag[i+1]  <= stage_tag[i];
			stage_func[i+1] <= stage_func[i];
			stage_prod[i+1] <= stage_prod[i] + partial;
		end

		// the last stage has no further slices to consume
		if (i < ex_cfg_pkg::mult_stages - 1) begin : g_shift
			always_ff @(posedge clock) begin
				stage_mcand[i+1]  <= stage_mcand[i] << ex_cfg_pkg::mult_step_bits;
				stage_mplier[i+1] <= stage_mplier[i] >> ex_cfg_pkg::mult_step_bits;
			end
		end
	end

	assign done = stage_valid[ex_cfg_pkg::mult_stages];
	assign tag  = stage_tag[ex_cfg_pkg::mult_stages];

	always_comb begin
		if (stage_func[ex_cfg_pkg::mult_stages] == rv_isa_pkg::mult_mul) begin
			product = stage_prod[ex_cfg_pkg::mult_stages][rv_isa_pkg::xlen-1:0];
		end else begin
			product = stage_prod[ex_cfg_pkg::mult_stages][2*rv_isa_pkg::xlen-1:rv_isa_pkg::xlen];
		end
	end

endmodule

//--- rtl/complete_queue.sv
// in-order completion FIFO, takes up to two results a cycle and emits one
// outputs are registered; an empty queue passes the first arrival straight through
`timescale 1ns/10ps

module complete_queue (
	input  logic              clock,
	input  logic              reset,
	input  logic              flush,
	input  logic              int_done,
	input  logic              int_take,
	input  ex_cfg_pkg::tag_t  int_tag,
	input  rv_isa_pkg::word_t int_result,
	input  rv_isa_pkg::word_t int_target,
	input  logic              mult_done,
	input  ex_cfg_pkg::tag_t  mult_tag,
	input  rv_isa_pkg::word_t mult_result,
	output logic              complete_valid,
	output logic              reg_wr_en,
	output logic              take_branch,
	output ex_cfg_pkg::tag_t  complete_tag,
	output rv_isa_pkg::word_t complete_result,
	output rv_isa_pkg::word_t branch_target
);

	// storage
	ex_cfg_pkg::tag_t  q_tag    [ex_cfg_pkg::cq_depth];
	rv_isa_pkg::word_t q_result [ex_cfg_pkg::cq_depth];
	logic              q_take   [ex_cfg_pkg::cq_depth];
	rv_isa_pkg::word_t q_target [ex_cfg_pkg::cq_depth];

	ex_cfg_pkg::cq_ptr_t head, tail, head_next, tail_next, wr1_ptr;
	logic [$clog2(ex_cfg_pkg::cq_depth+1)-1:0] count, count_next;

	ex_cfg_pkg::tag_t  in0_tag, wr0_tag, next_tag;
	rv_isa_pkg::word_t in0_result, wr0_result, next_result;
	rv_isa_pkg::word_t in0_target, wr0_target, next_target;
	logic              in0_take, wr0_take, next_take;
	logic              bypass, wr0_en, wr1_en, next_valid;

	//////////////////////////////////////////////////
	// ordering and next-state

	always_comb begin
		// multiplier result is the older instruction, it goes first
		if (mult_done) begin
			in0_tag    = mult_tag;
			in0_result = mult_result;
			in0_take   = 1'b0;
			in0_target = '0;
		end else begin
			in0_tag    = int_tag;
			in0_result = int_result;
			in0_take   = int_take;
			in0_target = int_target;
		end

		bypass  = (count == '0);  // first arrival skips storage
		wr1_ptr = tail + 1'b1;

		if (bypass) begin
			wr0_en      = mult_done & int_done;  // only the int half is stored
			wr0_tag     = int_tag;
			wr0_result  = int_result;
			wr0_take    = int_take;
			wr0_target  = int_target;
			next_valid  = mult_done | int_done;
			next_tag    = in0_tag;
			next_result = in0_result;
			next_take   = in0_take;
			next_target = in0_target;
		end else begin
			wr0_en      = mult_done | int_done;
			wr0_tag     = in0_tag;
			wr0_result  = in0_result;
			wr0_take    = in0_take;
			wr0_target  = in0_target;
			next_valid  = 1'b1;
			next_tag    = q_tag[head];
			next_result = q_result[head];
			next_take   = q_take[head];
			next_target = q_target[head];
		end
		wr1_en = !bypass & mult_done & int_done;  // second slot always the int entry

		head_next  = head;
		tail_next  = tail;
		count_next = count;
		if (!bypass) begin
			head_next  = head + 1'b1;
			count_next = count_next - 1'b1;
		end
		if (wr0_en) begin
			tail_next  = tail_next + 1'b1;
			count_next = count_next + 1'b1;
		end
		if (wr1_en) begin
			tail_next  = tail_next + 1'b1;
			count_next = count_next + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr0_en) begin
			q_tag[tail]    <= wr0_tag;
			q_result[tail] <= wr0_result;
			q_take[tail]   <= wr0_take;
			q_target[tail] <= wr0_target;
		end
		if (wr1_en) begin
			q_tag[wr1_ptr]    <= int_tag;
			q_result[wr1_ptr] <= int_result;
			q_take[wr1_ptr]   <= int_take;
			q_target[wr1_ptr] <= int_target;
		end
	end

	//////////////////////////////////////////////////
	// pointers and output register

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head           <= '0;
			tail           <= '0;
			count          <= '0;
			complete_valid <= 1'b0;
			take_branch    <= 1'b0;
		end else begin
			head           <= head_next;
			tail           <= tail_next;
			count          <= count_next;
			complete_valid <= next_valid;
			take_branch    <= next_valid & next_take;
		end
	end

	always_ff @(posedge clock) begin
		complete_tag    <= next_tag;
		complete_result <= next_result;
		branch_target   <= next_target;
	end

	assign reg_wr_en = complete_valid && (complete_tag != '0);  // no write for tag 0

endmodule

//--- rtl/ex_stage.sv
// execute stage top, integer path and multiplier side by side
// results merge in order through the completion queue
`timescale 1ns/10ps

module ex_stage (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  ex_cfg_pkg::exec_unit_t exec_unit,
	input  rv_isa_pkg::alu_func_t  alu_func,
	input  rv_isa_pkg::mult_func_t mult_func,
	input  rv_isa_pkg::opa_sel_t   opa_sel,
	input  rv_isa_pkg::opb_sel_t   opb_sel,
	input  rv_isa_pkg::inst_t      inst,
	input  rv_isa_pkg::word_t      pc,
	input  rv_isa_pkg::word_t      npc,
	input  rv_isa_pkg::word_t      rs1_value,
	input  rv_isa_pkg::word_t      rs2_value,
	input  ex_cfg_pkg::tag_t       dest_tag,
	input  logic                   cond_branch,
	input  logic                   uncond_branch,
	input  logic                   branch_haz,
	output logic                   complete_valid,
	output ex_cfg_pkg::tag_t       complete_tag,
	output rv_isa_pkg::word_t      complete_result,
	output logic                   reg_wr_en,
	output logic                   take_branch,
	output rv_isa_pkg::word_t      branch_target
);

	logic              int_start, mult_start;
	logic              int_done, int_take, mult_done;
	ex_cfg_pkg::tag_t  int_tag, mult_tag;
	rv_isa_pkg::word_t int_result, int_target, mult_result;

	// alu and branch both take the integer path
	assign mult_start = issue_valid && (exec_unit == ex_cfg_pkg::unit_mult);
	assign int_start  = issue_valid && (exec_unit != ex_cfg_pkg::unit_mult);

	int_exec u_int (
		.exec_unit(exec_unit), .start(int_start), .alu_func(alu_func),
		.opa_sel(opa_sel), .opb_sel(opb_sel), .inst(inst), .pc(pc), .npc(npc),
		.rs1_value(rs1_value), .rs2_value(rs2_value), .dest_tag(dest_tag),
		.cond_branch(cond_branch), .uncond_branch(uncond_branch),
		.done(int_done), .tag(int_tag), .result(int_result),
		.take(int_take), .target(int_target)
	);

	mult_pipe u_mult (
		.clock(clock), .reset(reset), .start(mult_start), .func(mult_func),
		.mcand(rs1_value), .mplier(rs2_value), .dest_tag(dest_tag), .flush(branch_haz),
		.done(mult_done), .tag(mult_tag), .product(mult_result)
	);

	complete_queue u_cq (
		.clock(clock), .reset(reset), .flush(branch_haz),
		.int_done(int_done), .int_take(int_take), .int_tag(int_tag),
		.int_result(int_result), .int_target(int_target),
		.mult_done(mult_done), .mult_tag(mult_tag), .mult_result(mult_result),
		.complete_valid(complete_valid), .reg_wr_en(reg_wr_en), .take_branch(take_branch),
		.complete_tag(complete_tag), .complete_result(complete_result),
		.branch_target(branch_target)
	);

endmodule

//--- dv/ex_stage_sva.sv
// concurrent checks on the execute stage outputs and completion queue fill
// bound into every ex_stage instance, the testbench reads fail_count at the end
`timescale 1ns/10ps

module ex_stage_sva (
	input logic                                        clock,
	input logic                                        reset,
	input logic                                        branch_haz,
	input logic                                        complete_valid,
	input logic                                        reg_wr_en,
	input logic                                        take_branch,
	input logic [$clog2(ex_cfg_pkg::cq_depth+1)-1:0]   cq_count
);

	int fail_count;

	initial fail_count = 0;

	//////////////////////////////////////////////////
	// output relations

	wr_needs_valid: assert property (@(posedge clock) reg_wr_en |-> complete_valid)
		else begin
			$error("reg_wr_en without complete_valid");
			fail_count = fail_count + 1;
		end

	// hazard empties the queue, nothing completes next cycle
	flush_quiet: assert property (@(posedge clock) disable iff (reset)
		branch_haz |=> !complete_valid)
		else begin
			$error("completion in the cycle after branch_haz");
			fail_count = fail_count + 1;
		end

	count_bound: assert property (@(posedge clock) disable iff (reset)
		int'(cq_count) <= ex_cfg_pkg::cq_depth)
		else begin
			$error("completion queue count above its depth");
			fail_count = fail_count + 1;
		end

	reset_quiet: assert property (@(posedge clock)
		reset |=> !complete_valid && !reg_wr_en && !take_branch)
		else begin
			$error("outputs active under reset");
			fail_count = fail_count + 1;
		end

endmodule

bind ex_stage ex_stage_sva u_sva (
	.clock(clock), .reset(reset), .branch_haz(branch_haz),
	.complete_valid(complete_valid), .reg_wr_en(reg_wr_en), .take_branch(take_branch),
	.cq_count(u_cq.count)
);

//--- dv/ex_stage_tb.sv
// testbench for the execute stage, random ALU, multiply and branch ops against a reference model
// every completion pops the model queue and is checked by immediate assertions
`timescale 1ns/10ps

module ex_stage_tb;

	localparam int clock_period    = 20;
	localparam int reset_cycles    = 16;
	localparam int n_alu           = 200;
	localparam int n_mult          = 40;
	localparam int n_branch        = 60;
	localparam int n_mixed         = 40;
	localparam int n_ops           = n_alu + n_mult + n_branch + n_mixed + 20;  // short tests
	localparam int watchdog_cycles = 3 * n_ops + reset_cycles + 50;

	typedef struct {
		ex_cfg_pkg::tag_t  tag;
		rv_isa_pkg::word_t result;
		logic              take;
		rv_isa_pkg::word_t target;
		logic              is_branch;  // target only checked for branches
		int                test;
	} exp_t;

	logic                   clock, reset, issue_valid, cond_branch, uncond_branch, branch_haz;
	ex_cfg_pkg::exec_unit_t exec_unit;
	rv_isa_pkg::alu_func_t  alu_func;
	rv_isa_pkg::mult_func_t mult_func;
	rv_isa_pkg::opa_sel_t   opa_sel;
	rv_isa_pkg::opb_sel_t   opb_sel;
	rv_isa_pkg::inst_t      inst;
	rv_isa_pkg::word_t      pc, npc, rs1_value, rs2_value;
	ex_cfg_pkg::tag_t       dest_tag;
	logic                   complete_valid, reg_wr_en, take_branch;
	ex_cfg_pkg::tag_t       complete_tag;
	rv_isa_pkg::word_t      complete_result, branch_target;

	exp_t   exp_q[$];
	exp_t   pend_q[$];  // multiplies still in the pipe
	exp_t   got;
	int     pend_at[$];
	int     cycle, errors, test_id, i;
	logic   issued_any;
	integer seed = 32'ha4e8;

	ex_stage i_ex_stage (.*);

	//////////////////////////////////////////////////
	// reference model

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic rv_isa_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	function automatic string test_label(int id);
		case (id)
			0:       return "alu";
			1:       return "mult";
			2:       return "branch";
			3:       return "order";
			4:       return "flush";
			default: return "zero_reg";
		endcase
	endfunction

	function automatic logic [2:0] pick_funct3();
		case (rand_below(6))
			0:       return 3'b000;
			1:       return 3'b001;
			2:       return 3'b100;
			3:       return 3'b101;
			4:       return 3'b110;
			default: return 3'b111;
		endcase
	endfunction

	function automatic rv_isa_pkg::word_t alu_ref(rv_isa_pkg::alu_func_t f,
			rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
		logic [63:0] wide;
		wide = {{32{a[31]}}, a} >> b[4:0];  // arithmetic shift via sign-extended word
		case (f)
			rv_isa_pkg::alu_add:  return a + b;
			rv_isa_pkg::alu_sub:  return a + ~b + 32'd1;
			rv_isa_pkg::alu_and:  return a & b;
			rv_isa_pkg::alu_or:   return a | b;
			rv_isa_pkg::alu_xor:  return a ^ b;
			rv_isa_pkg::alu_slt:  return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
			rv_isa_pkg::alu_sltu: return {31'd0, a < b};
			rv_isa_pkg::alu_sll:  return a << b[4:0];
			rv_isa_pkg::alu_srl:  return a >> b[4:0];
			default:              return wide[31:0];
		endcase
	endfunction

	function automatic logic cond_ref(logic [2:0] f3, rv_isa_pkg::word_t a,
			rv_isa_pkg::word_t b);
		rv_isa_pkg::word_t sa, sb;
		sa = a ^ 32'h8000_0000;  // biased, unsigned compare gives signed order
		sb = b ^ 32'h8000_0000;
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return sa < sb;
			3'b101:  return sa >= sb;
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic rv_isa_pkg::word_t mult_ref(rv_isa_pkg::mult_func_t f,
			rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
		logic [63:0] ea, eb, p;
		ea = {{32{a[31] && (f != rv_isa_pkg::mult_mulhu)}}, a};
		eb = {{32{b[31] && (f == rv_isa_pkg::mult_mul || f == rv_isa_pkg::mult_mulh)}}, b};
		p  = ea * eb;
		return (f == rv_isa_pkg::mult_mul) ? p[31:0] : p[63:32];
	endfunction

	// expected completion for the op on the inputs right now
	function automatic exp_t model_entry();
		exp_t              e;
		rv_isa_pkg::word_t opa, opb, i_imm, b_imm;
		i_imm = {{20{inst[31]}}, inst[31:20]};
		b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		case (opa_sel)
			rv_isa_pkg::opa_rs1: opa = rs1_value;
			rv_isa_pkg::opa_npc: opa = npc;
			rv_isa_pkg::opa_pc:  opa = pc;
			default:             opa = '0;
		endcase
		case (opb_sel)
			rv_isa_pkg::opb_rs2:   opb = rs2_value;
			rv_isa_pkg::opb_i_imm: opb = i_imm;
			default:               opb = b_imm;
		endcase
		e.tag  = dest_tag;
		e.test = test_id;
		if (exec_unit == ex_cfg_pkg::unit_mult) begin
			e.result    = mult_ref(mult_func, rs1_value, rs2_value);
			e.take      = 1'b0;
			e.target    = '0;
			e.is_branch = 1'b0;
		end else begin
			e.is_branch = (exec_unit == ex_cfg_pkg::unit_branch) || uncond_branch;
			e.result    = e.is_branch ? npc : alu_ref(alu_func, opa, opb);
			e.take      = uncond_branch || (cond_branch && cond_ref(inst[14:12], rs1_value,
				rs2_value));
			e.target    = opa + opb;
		end
		return e;
	endfunction

	// arrival order at the queue, multiply first on a shared edge
	always @(posedge clock) begin
		cycle = cycle + 1;
		if (reset || branch_haz) begin
			exp_q.delete();
			pend_q.delete();
			pend_at.delete();
		end else begin
			if (pend_at.size() != 0 && pend_at[0] == cycle) begin
				exp_q.push_back(pend_q.pop_front());
				pend_at.delete(0);
			end
			if (issue_valid) begin
				issued_any = 1'b1;
				if (exec_unit == ex_cfg_pkg::unit_mult) begin
					pend_q.push_back(model_entry());
					pend_at.push_back(cycle + ex_cfg_pkg::mult_stages);
				end else begin
					exp_q.push_back(model_entry());
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// checking, mid-cycle where outputs are stable

	task automatic report_mismatch(string field, rv_isa_pkg::word_t expected,
			rv_isa_pkg::word_t actual);
		errors++;
		$display("mismatch %s %s: expected %h, actual %h", test_label(got.test), field,
			expected, actual);
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			if (!issued_any) begin
				assert (!complete_valid && !reg_wr_en && !take_branch) else begin
					errors++;
					$display("control outputs active before the first issue");
				end
			end
			if (complete_valid && exp_q.size() == 0) begin
				errors++;
				$display("completion with tag %0d that no issued op explains", complete_tag);
			end else if (complete_valid) begin
				got = exp_q.pop_front();
				assert (complete_tag == got.tag) else
					report_mismatch("tag", rv_isa_pkg::word_t'(got.tag),
						rv_isa_pkg::word_t'(complete_tag));
				assert (complete_result == got.result) else
					report_mismatch("result", got.result, complete_result);
				assert (take_branch == got.take) else
					report_mismatch("take", rv_isa_pkg::word_t'(got.take),
						rv_isa_pkg::word_t'(take_branch));
				assert (reg_wr_en == (got.tag != '0)) else
					report_mismatch("reg_wr_en", rv_isa_pkg::word_t'(got.tag != '0),
						rv_isa_pkg::word_t'(reg_wr_en));
				if (got.is_branch) begin
					assert (branch_target == got.target) else
						report_mismatch("target", got.target, branch_target);
				end
			end else begin
				assert (!take_branch && !reg_wr_en) else begin
					errors++;
					$display("take or write enable raised without a completion");
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic set_idle();
		issue_valid = 1'b0;
	endtask

	task automatic set_op(ex_cfg_pkg::exec_unit_t unit);
		issue_valid   = 1'b1;
		exec_unit     = unit;
		alu_func      = rv_isa_pkg::alu_func_t'(4'(rand_below(10)));
		mult_func     = rv_isa_pkg::mult_func_t'(2'(rand_below(4)));
		opa_sel       = rv_isa_pkg::opa_sel_t'(2'(rand_below(4)));
		opb_sel       = rv_isa_pkg::opb_sel_t'(2'(rand_below(3)));
		inst          = rand_word();
		pc            = rand_word() & 32'hffff_fffc;
		npc           = pc + 32'd4;
		rs1_value     = rand_word();
		rs2_value     = (rand_below(4) == 0) ? rs1_value : rand_word();  // ties for eq, ge
		dest_tag      = ex_cfg_pkg::tag_t'(6'(rand_below(64)));
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		if (unit == ex_cfg_pkg::unit_branch) begin
			uncond_branch = (rand_below(4) == 0);
			cond_branch   = !uncond_branch;
			inst[14:12]   = pick_funct3();
		end
	endtask

	// waits for the model to drain through completions
	task automatic wait_idle();
		int guard;
		guard = 0;
		while ((exp_q.size() != 0 || pend_q.size() != 0) && guard < 100) begin
			@(negedge clock);
			guard++;
		end
		if (guard >= 100) begin
			errors++;
			$display("%s ops still not complete after 100 cycles", test_label(test_id));
		end
		step();
	endtask

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		reset = 1'b1;
		branch_haz = 1'b0;
		issue_valid = 1'b0;
		exec_unit = ex_cfg_pkg::unit_alu;
		alu_func = rv_isa_pkg::alu_add;
		mult_func = rv_isa_pkg::mult_mul;
		opa_sel = rv_isa_pkg::opa_rs1;
		opb_sel = rv_isa_pkg::opb_rs2;
		inst = '0;
		pc = '0;
		npc = '0;
		rs1_value = '0;
		rs2_value = '0;
		dest_tag = '0;
		cond_branch = 1'b0;
		uncond_branch = 1'b0;
		errors = 0;
		cycle = 0;
		test_id = 0;
		issued_any = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		#2 reset = 1'b0;
		repeat (3) step();  // quiet outputs before any issue

		// alu ops with an empty queue, one cycle latency each
		for (i = 0; i < n_alu; i++) begin
			set_op(ex_cfg_pkg::unit_alu);
			step();
			set_idle();
			@(negedge clock);
			assert (complete_valid) else begin
				errors++;
				$display("alu op %0d did not complete one cycle after issue", i);
			end
			step();
		end
		wait_idle();

		test_id = 1;
		for (i = 0; i < n_mult; i++) begin
			set_op(ex_cfg_pkg::unit_mult);  // back to back
			step();
		end
		set_idle();
		wait_idle();

		test_id = 2;
		for (i = 0; i < n_branch; i++) begin
			set_op(ex_cfg_pkg::unit_branch);
			step();
			set_idle();
			step();
		end
		wait_idle();

		// multiply and alu reach the queue on the same edge
		test_id = 3;
		set_op(ex_cfg_pkg::unit_mult);
		step();
		set_idle();
		repeat (ex_cfg_pkg::mult_stages - 1) step();
		set_op(ex_cfg_pkg::unit_alu);
		step();
		for (i = 0; i < n_mixed; i++) begin
			case (rand_below(4))
				0:       set_op(ex_cfg_pkg::unit_alu);
				1:       set_op(ex_cfg_pkg::unit_mult);
				2:       set_op(ex_cfg_pkg::unit_branch);
				default: set_idle();
			endcase
			step();
		end
		set_idle();
		wait_idle();

		// hazard with multiplies in flight and entries queued
		test_id = 4;
		for (i = 0; i < 4; i++) begin
			set_op(ex_cfg_pkg::unit_mult);
			step();
		end
		for (i = 0; i < 2; i++) begin
			set_op(ex_cfg_pkg::unit_alu);
			step();
		end
		set_op(ex_cfg_pkg::unit_alu);
		branch_haz = 1'b1;  // squashes this op too
		step();
		branch_haz = 1'b0;
		set_idle();
		step();
		for (i = 0; i < 6; i++) begin
			set_op((i % 2 == 0) ? ex_cfg_pkg::unit_mult : ex_cfg_pkg::unit_alu);
			step();
		end
		set_idle();
		wait_idle();

		test_id = 5;
		set_op(ex_cfg_pkg::unit_alu);
		dest_tag = '0;
		step();
		set_op(ex_cfg_pkg::unit_mult);
		dest_tag = '0;
		step();
		set_idle();
		wait_idle();

		$display("errors: %0d in checks, %0d in bound assertions", errors,
			i_ex_stage.u_sva.fail_count);
		if (errors == 0 && i_ex_stage.u_sva.fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- sim.f
rtl/rv_isa_pkg.sv
rtl/ex_cfg_pkg.sv
rtl/int_exec.sv
rtl/mult_pipe.sv
rtl/complete_queue.sv
rtl/ex_stage.sv
dv/ex_stage_sva.sv
dv/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ex_stage_tb \
	-o ex_stage_tb_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/ex_stage_tb_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}
